// ==== source/revo_timing_pkg.sv ====
`default_nettype none

package revo_timing_pkg;

	// Samples per clock127 word from the deserializer
	localparam int SAMPLE_WIDTH = 4;

	// Default histogram counter width
	localparam int HIST_WIDTH_DEFAULT = 33;

	typedef logic [SAMPLE_WIDTH-1:0] sample_word_t;

	// Upper bit picks the half, lower bit the member within it
	typedef logic [1:0] phase_sel_t;

	// --------------------------------------------------
	// Pulse words for an edge at each sample position
	localparam sample_word_t PATTERN_00 = 4'b1110;
	localparam sample_word_t PATTERN_01 = 4'b1100;
	localparam sample_word_t PATTERN_10 = 4'b1000;
	localparam sample_word_t PATTERN_11 = 4'b1111;

	typedef struct packed {
		logic [HIST_WIDTH_DEFAULT-1:0] count_00;
		logic [HIST_WIDTH_DEFAULT-1:0] count_01;
		logic [HIST_WIDTH_DEFAULT-1:0] count_10;
		logic [HIST_WIDTH_DEFAULT-1:0] count_11;
	} hist_counts_t;

	// First and second half of one clock127 cycle
	typedef struct packed {
		logic rise;
		logic fall;
	} ddr_pair_t;

endpackage

`default_nettype wire

// ==== source/revo_edge_pulser.sv ====
`default_nettype none

module revo_edge_pulser (
	input wire logic clock127,
	input wire logic oserdes_reset,
	input wire revo_timing_pkg::sample_word_t sample_word,
	output revo_timing_pkg::sample_word_t pulse_word
);
	import revo_timing_pkg::*;

	// Previous word so that a bit held high across words gives one pulse only
	sample_word_t previous_word;

	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			previous_word <= '0;
			pulse_word <= '0;
		end else begin
			previous_word <= sample_word;
			// Bits that went from 0 to 1 between two words
			pulse_word <= sample_word & ~previous_word;
		end
	end

endmodule

`default_nettype wire

// ==== source/phase_histogram.sv ====
`default_nettype none

module phase_histogram #(
	parameter int HIST_WIDTH = 33,
	parameter type counts_t = revo_timing_pkg::hist_counts_t
) (
	input wire logic clock127,
	input wire logic oserdes_reset,
	input wire logic rf_locked,
	input wire revo_timing_pkg::sample_word_t pulse_word,
	output counts_t counts,
	output logic [HIST_WIDTH+1:0] pulse_count
);
	import revo_timing_pkg::*;

	// One bit per position: 00, 01, 10, 11
	logic [3:0] hit;
	logic [3:0] full;

	// --------------------------------------------------
	// Classify the pulse word and ignore any other pattern
	always_comb begin
		hit = '0;
		case (pulse_word)
			PATTERN_00: hit[0] = 1'b1;
			PATTERN_01: hit[1] = 1'b1;
			PATTERN_10: hit[2] = 1'b1;
			PATTERN_11: hit[3] = 1'b1;
			default: hit = '0;
		endcase
	end

	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			counts <= '0;
			pulse_count <= '0;
		end else if (!rf_locked) begin
			counts <= '0;
			pulse_count <= '0;
		end else begin
			if (hit[0])
				counts.count_00 <= counts.count_00 + 1'b1;
			if (hit[1])
				counts.count_01 <= counts.count_01 + 1'b1;
			if (hit[2])
				counts.count_10 <= counts.count_10 + 1'b1;
			if (hit[3])
				counts.count_11 <= counts.count_11 + 1'b1;
			if (|hit)
				pulse_count <= pulse_count + 1'b1;
		end
	end

	// --------------------------------------------------
	// A saturated counter that is hit again would wrap
	assign full = {&counts.count_11, &counts.count_10, &counts.count_01, &counts.count_00};

	assert property (@(posedge clock127) disable iff (oserdes_reset)
		rf_locked |-> !(|(hit & full)));

endmodule

`default_nettype wire

// ==== source/phase_select_fsm.sv ====
`default_nettype none

module phase_select_fsm #(
	parameter int HIST_WIDTH = 33,
	parameter int PULSE_COUNT_MIN = 131072,
	parameter type counts_t = revo_timing_pkg::hist_counts_t
) (
	input wire logic clock127,
	input wire logic oserdes_reset,
	input wire logic rf_locked,
	input wire counts_t counts,
	input wire logic [HIST_WIDTH+1:0] pulse_count,
	output revo_timing_pkg::phase_sel_t phase_select,
	output logic phase_locked
);
	import revo_timing_pkg::*;

	typedef enum logic {ACQUIRE, LOCKED} state_t;

	// Stage one result with the winner of each half
	typedef struct packed {
		logic sel_0x;
		logic [HIST_WIDTH-1:0] max_0x;
		logic sel_1x;
		logic [HIST_WIDTH-1:0] max_1x;
		logic over_min;
	} half_pick_t;

	localparam logic [HIST_WIDTH+1:0] MIN_COUNT = (HIST_WIDTH+2)'(PULSE_COUNT_MIN);

	state_t state;
	half_pick_t pick;
	phase_sel_t best;
	logic best_over_min;
	logic over_min;

	assign over_min = pulse_count > MIN_COUNT;

	// --------------------------------------------------
	// Two stage choice with the over-count flag carried alongside
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			pick <= '0;
			best <= '0;
			best_over_min <= 1'b0;
		end else if (!rf_locked) begin
			pick <= '0;
			best <= '0;
			best_over_min <= 1'b0;
		end else begin
			// Ties go to the lower member
			pick.sel_0x <= counts.count_00 < counts.count_01;
			pick.max_0x <= (counts.count_00 < counts.count_01) ? counts.count_01 : counts.count_00;
			pick.sel_1x <= counts.count_10 < counts.count_11;
			pick.max_1x <= (counts.count_10 < counts.count_11) ? counts.count_11 : counts.count_10;
			pick.over_min <= over_min;
			// Ties go to half 0x
			if (pick.max_0x < pick.max_1x)
				best <= {1'b1, pick.sel_1x};
			else
				best <= {1'b0, pick.sel_0x};
			best_over_min <= pick.over_min;
		end
	end

	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			state <= ACQUIRE;
			phase_select <= '0;
		end else if (!rf_locked) begin
			state <= ACQUIRE;
			phase_select <= '0;
		end else if (state == ACQUIRE && best_over_min) begin
			phase_select <= best;
			state <= LOCKED;
		end
	end

	assign phase_locked = (state == LOCKED);

	// Select is frozen for as long as the lock lasts
	assert property (@(posedge clock127) disable iff (oserdes_reset)
		(state == LOCKED) && rf_locked |=> $stable(phase_select));

endmodule

`default_nettype wire

// ==== source/revo_activity_timer.sv ====
`default_nettype none

module revo_activity_timer #(
	parameter int REVO_WINDOW = 524288
) (
	input wire logic clock127,
	input wire logic oserdes_reset,
	input wire revo_timing_pkg::sample_word_t pulse_word,
	output logic led_revo
);
	localparam int WINDOW_BITS = $clog2(REVO_WINDOW);
	localparam logic [WINDOW_BITS-1:0] WINDOW_LAST = WINDOW_BITS'(REVO_WINDOW - 1);

	logic [WINDOW_BITS-1:0] window_count;
	logic saw_pulse;

	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			window_count <= '0;
			saw_pulse <= 1'b0;
			led_revo <= 1'b0;
		end else if (window_count == WINDOW_LAST) begin
			// A pulse in the last cycle of the window still counts
			window_count <= '0;
			led_revo <= saw_pulse | (|pulse_word);
			saw_pulse <= 1'b0;
		end else begin
			window_count <= window_count + 1'b1;
			if (|pulse_word)
				saw_pulse <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/revo_trigger_encoder.sv ====
`default_nettype none

module revo_trigger_encoder (
	input wire logic clock127,
	input wire logic oserdes_reset,
	input wire logic phase_locked,
	input wire revo_timing_pkg::sample_word_t pulse_word,
	output revo_timing_pkg::ddr_pair_t clock_pair,
	output revo_timing_pkg::ddr_pair_t trigger_pair
);
	logic enabled;
	logic long_marker;
	logic long_marker_d;
	logic trigger;

	// --------------------------------------------------
	// Marker stretch and edge detect down to one cycle
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			enabled <= 1'b0;
			long_marker <= 1'b0;
			long_marker_d <= 1'b0;
			trigger <= 1'b0;
		end else if (!phase_locked) begin
			enabled <= 1'b0;
			long_marker <= 1'b0;
			long_marker_d <= 1'b0;
			trigger <= 1'b0;
		end else begin
			enabled <= 1'b1;
			long_marker <= |pulse_word;
			long_marker_d <= long_marker;
			trigger <= long_marker & ~long_marker_d;
		end
	end

	// --------------------------------------------------
	// Reference clock is 1 then 0; trigger line is inverted
	// trigger then trigger, so the XOR of the pairs is the trigger
	assign clock_pair = '{rise: enabled, fall: 1'b0};
	assign trigger_pair = '{rise: enabled & ~trigger, fall: trigger};

	assert property (@(posedge clock127) disable iff (oserdes_reset)
		trigger |=> !trigger);

endmodule

`default_nettype wire

// ==== source/revo_receiver_top.sv ====
`default_nettype none

module revo_receiver_top #(
	parameter int HIST_WIDTH = revo_timing_pkg::HIST_WIDTH_DEFAULT,
	parameter int PULSE_COUNT_MIN = 131072,
	parameter int REVO_WINDOW = 524288,
	// Counter fields must be HIST_WIDTH wide
	parameter type counts_t = revo_timing_pkg::hist_counts_t
) (
	input wire logic clock127,
	input wire logic oserdes_reset,
	input wire logic rf_locked,
	input wire revo_timing_pkg::sample_word_t sample_word,
	output revo_timing_pkg::phase_sel_t phase_select,
	output logic phase_locked,
	output logic led_revo,
	output revo_timing_pkg::ddr_pair_t clock_pair,
	output revo_timing_pkg::ddr_pair_t trigger_pair
);
	import revo_timing_pkg::*;

	sample_word_t pulse_word;
	counts_t counts;
	logic [HIST_WIDTH+1:0] pulse_count;

	revo_edge_pulser edge_pulser (
		.clock127(clock127), .oserdes_reset(oserdes_reset),
		.sample_word(sample_word), .pulse_word(pulse_word)
	);

	phase_histogram #(.HIST_WIDTH(HIST_WIDTH), .counts_t(counts_t)) histogram (
		.clock127(clock127), .oserdes_reset(oserdes_reset), .rf_locked(rf_locked),
		.pulse_word(pulse_word), .counts(counts), .pulse_count(pulse_count)
	);

	phase_select_fsm #(
		.HIST_WIDTH(HIST_WIDTH), .PULSE_COUNT_MIN(PULSE_COUNT_MIN), .counts_t(counts_t)
	) select_fsm (
		.clock127(clock127), .oserdes_reset(oserdes_reset), .rf_locked(rf_locked),
		.counts(counts), .pulse_count(pulse_count),
		.phase_select(phase_select), .phase_locked(phase_locked)
	);

	revo_activity_timer #(.REVO_WINDOW(REVO_WINDOW)) activity_timer (
		.clock127(clock127), .oserdes_reset(oserdes_reset),
		.pulse_word(pulse_word), .led_revo(led_revo)
	);

	revo_trigger_encoder trigger_encoder (
		.clock127(clock127), .oserdes_reset(oserdes_reset), .phase_locked(phase_locked),
		.pulse_word(pulse_word), .clock_pair(clock_pair), .trigger_pair(trigger_pair)
	);

endmodule

`default_nettype wire

// ==== tb/revo_receiver_tb.sv ====
`default_nettype none

module revo_receiver_tb;
	import revo_timing_pkg::*;

	localparam int PULSE_COUNT_MIN = 20;
	localparam int REVO_WINDOW = 64;
	localparam int LOCK_TIMEOUT = 16;

	logic clock127;
	logic oserdes_reset;
	logic rf_locked;
	sample_word_t sample_word;
	phase_sel_t phase_select;
	logic phase_locked;
	logic led_revo;
	ddr_pair_t clock_pair;
	ddr_pair_t trigger_pair;

	logic [15:0] lfsr_state;
	int model_count [4];
	int model_total;
	int pulse_plan [$];
	int check_count;
	int error_count;
	int test_start_errors;

	revo_receiver_top #(
		.PULSE_COUNT_MIN(PULSE_COUNT_MIN),
		.REVO_WINDOW(REVO_WINDOW)
	) UUT (
		.clock127(clock127), .oserdes_reset(oserdes_reset), .rf_locked(rf_locked),
		.sample_word(sample_word), .phase_select(phase_select), .phase_locked(phase_locked),
		.led_revo(led_revo), .clock_pair(clock_pair), .trigger_pair(trigger_pair)
	);

	always #2 clock127 = ~clock127;

	// --------------------------------------------------
	// Random source and reference model
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 16'hB400;
		return next;
	endfunction

	task automatic take_random_bits(input int count, output int value);
		int i;
		value = 0;
		for (i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Codes 0 to 3 are the edge positions and 4 is an unclassified edge
	function automatic sample_word_t code_word(input int code);
		case (code)
			0: return 4'b1110;
			1: return 4'b1100;
			2: return 4'b1000;
			3: return 4'b1111;
			default: return 4'b0110;
		endcase
	endfunction

	// Most frequent position wins and a tie goes to the lower position
	function automatic phase_sel_t expected_phase(input int c00, input int c01,
		input int c10, input int c11);
		int counts [4];
		int best;
		int i;
		counts[0] = c00;
		counts[1] = c01;
		counts[2] = c10;
		counts[3] = c11;
		best = 0;
		for (i = 1; i < 4; i++) begin
			if (counts[i] > counts[best])
				best = i;
		end
		return phase_sel_t'(best);
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic finish_test(input string name);
		$display("Test %s done, %0d errors", name, error_count - test_start_errors);
		test_start_errors = error_count;
	endtask

	// --------------------------------------------------
	// Stimulus changes on the rising edge and outputs are read on the falling edge
	task automatic drive_cycle(input sample_word_t word);
		@(posedge clock127);
		sample_word <= word;
		@(negedge clock127);
	endtask

	task automatic set_rf_locked(input logic value);
		@(posedge clock127);
		rf_locked <= value;
		sample_word <= '0;
		@(negedge clock127);
	endtask

	task automatic check_cleared();
		check_value("phase_locked", 64'(phase_locked), 64'(0));
		check_value("phase_select", 64'(phase_select), 64'(0));
		check_value("clock_pair", 64'(clock_pair), 64'(0));
		check_value("trigger_pair", 64'(trigger_pair), 64'(0));
	endtask

	// Sends the shuffled pulse_plan and then waits for lock and checks the select
	task automatic acquire_phase(input phase_sel_t expected_select);
		int i;
		int j;
		int pick;
		int swap;
		int code;
		int gap;
		int waited;
		for (i = 0; i < 4; i++)
			model_count[i] = 0;
		model_total = 0;
		for (i = pulse_plan.size() - 1; i > 0; i--) begin
			take_random_bits(5, pick);
			j = pick % (i + 1);
			swap = pulse_plan[i];
			pulse_plan[i] = pulse_plan[j];
			pulse_plan[j] = swap;
		end
		for (i = 0; i < pulse_plan.size(); i++) begin
			code = pulse_plan[i];
			drive_cycle(code_word(code));
			if (code < 4) begin
				model_count[code]++;
				model_total++;
			end
			take_random_bits(3, gap);
			repeat (gap + 4) drive_cycle('0);
			if (model_total <= PULSE_COUNT_MIN)
				check_value("phase_locked", 64'(phase_locked), 64'(0));
		end
		waited = 0;
		while (!phase_locked && waited < LOCK_TIMEOUT) begin
			drive_cycle('0);
			waited++;
		end
		if (!phase_locked) begin
			error_count++;
			$display("Timeout: phase_locked did not rise within %0d cycles", LOCK_TIMEOUT);
		end
		check_value("phase_select", 64'(phase_select), 64'(expected_phase(model_count[0],
			model_count[1], model_count[2], model_count[3])));
		check_value("phase_select", 64'(phase_select), 64'(expected_select));
	endtask

	// --------------------------------------------------
	task automatic reset_values_test();
		set_rf_locked(1'b1);
		repeat (8) begin
			drive_cycle('0);
			check_cleared();
			check_value("led_revo", 64'(led_revo), 64'(0));
		end
		finish_test("1 reset values");
	endtask

	task automatic acquisition_test();
		int n;
		pulse_plan.delete();
		for (n = 0; n < 12; n++)
			pulse_plan.push_back(2);
		for (n = 0; n < 3; n++) begin
			pulse_plan.push_back(0);
			pulse_plan.push_back(1);
			pulse_plan.push_back(3);
		end
		pulse_plan.push_back(4);
		pulse_plan.push_back(4);
		acquire_phase(2'b10);
		finish_test("2 acquisition");
	endtask

	task automatic tie_rule_test();
		int n;
		set_rf_locked(1'b0);
		repeat (3) drive_cycle('0);
		check_cleared();
		set_rf_locked(1'b1);
		// Lock follows the 21st pulse and one pulse at 00 keeps the pair level
		pulse_plan.delete();
		pulse_plan.push_back(0);
		for (n = 0; n < 10; n++) begin
			pulse_plan.push_back(2);
			pulse_plan.push_back(3);
		end
		acquire_phase(2'b10);
		set_rf_locked(1'b0);
		repeat (3) drive_cycle('0);
		check_cleared();
		set_rf_locked(1'b1);
		pulse_plan.delete();
		pulse_plan.push_back(0);
		for (n = 0; n < 10; n++) begin
			pulse_plan.push_back(1);
			pulse_plan.push_back(3);
		end
		acquire_phase(2'b01);
		finish_test("3 tie rule");
	endtask

	task automatic encoding_test();
		int edge_index;
		int code;
		int hold;
		int gap;
		int step;
		repeat (2) drive_cycle('0);
		for (edge_index = 0; edge_index < 6; edge_index++) begin
			take_random_bits(3, code);
			take_random_bits(2, hold);
			take_random_bits(3, gap);
			// Held copies of the edge word carry no new rising bit
			for (step = 0; step < hold + gap + 5; step++) begin
				drive_cycle(step <= hold ? code_word(code % 5) : 4'b0000);
				check_value("clock_pair", 64'(clock_pair), 64'(2'b10));
				check_value("clock_pair ^ trigger_pair", 64'(clock_pair ^ trigger_pair),
					(step == 3) ? 64'(2'b11) : 64'(0));
			end
		end
		finish_test("4 trigger encoding");
	endtask

	task automatic activity_led_test();
		int waited;
		repeat (2 * REVO_WINDOW + 8) drive_cycle('0);
		check_value("led_revo", 64'(led_revo), 64'(0));
		drive_cycle(4'b1000);
		waited = 0;
		while (!led_revo && waited < REVO_WINDOW + 8) begin
			drive_cycle('0);
			waited++;
		end
		if (!led_revo) begin
			error_count++;
			$display("Timeout: led_revo did not rise within %0d cycles of a pulse", waited);
		end
		repeat (REVO_WINDOW / 2) drive_cycle('0);
		check_value("led_revo", 64'(led_revo), 64'(1));
		repeat (REVO_WINDOW) drive_cycle('0);
		check_value("led_revo", 64'(led_revo), 64'(0));
		finish_test("5 activity LED");
	endtask

	initial begin
		clock127 = 1'b0;
		oserdes_reset = 1'b1;
		rf_locked = 1'b0;
		sample_word = '0;
		lfsr_state = 16'd38553;
		model_total = 0;
		check_count = 0;
		error_count = 0;
		test_start_errors = 0;
		repeat (3) @(posedge clock127);
		oserdes_reset <= 1'b0;
		reset_values_test();
		acquisition_test();
		tie_rule_test();
		encoding_test();
		activity_led_test();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/revo_timing_pkg.sv
source/revo_edge_pulser.sv
source/phase_histogram.sv
source/phase_select_fsm.sv
source/revo_activity_timer.sv
source/revo_trigger_encoder.sv
source/revo_receiver_top.sv
tb/revo_receiver_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module revo_receiver_tb \
	-f filelist.f -o revo_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/revo_sim > sim.log 2>&1 ; cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
